// ==== tb.f ====
logic/rvPkg.sv
logic/ctrlIf.sv
logic/instrDecode.sv
logic/regFile.sv
logic/aluExecute.sv
logic/resultSelect.sv
logic/rvCore.sv
tb/rvCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the rvCore testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f tb.f --top-module rvCoreTb -o rvCoreSim; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/rvCoreSim 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF 'All tests passed!'; then
    exit 0
else
    exit 1
fi

// ==== tb/rvCoreTb.sv ====
`timescale 1ns/1ps

module rvCoreTb;

    localparam logic [6:0] opI  = 7'b0010011;
    localparam logic [6:0] opL  = 7'b0000011;
    localparam logic [6:0] opJr = 7'b1100111;

    logic        rstn;
    logic        rstN;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        wbEn;
    logic [4:0]  wbReg;
    logic [31:0] wbData;

    string       names [$];
    logic [31:0] instrs [$];
    logic [31:0] expPc [$];
    logic        expEn [$];
    logic [4:0]  expReg [$];
    logic [31:0] expData [$];

    int errors;
    int checks;
    int cycles;
    int cycleLimit;
    int row;

    rvCore UUT (
        .rstn(rstn), .rstN(rstN), .instr(instr), .pc(pc),
        .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData)
    );

    function automatic logic [31:0] rType(input int f7, input int rs2, input int rs1,
                                          input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] iType(input int imm, input int rs1, input int f3,
                                          input int rd, input logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] sType(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] bType(input int imm, input int rs2, input int rs1,
                                          input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] jType(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic addTest(input string name, input logic [31:0] code,
                           input logic [31:0] pcExp, input logic en, input int rd,
                           input logic [31:0] data);
        names.push_back(name);
        instrs.push_back(code);
        expPc.push_back(pcExp);
        expEn.push_back(en);
        expReg.push_back(rd[4:0]);
        expData.push_back(data);
    endtask

    // x1 = 6 and x2 = -3 feed most of the rows below
    task automatic buildProgram();
        addTest("addi x1", iType(6, 0, 0, 1, opI), 0, 1'b1, 1, 6);
        addTest("addi x2", iType(-3, 0, 0, 2, opI), 4, 1'b1, 2, 32'hFFFFFFFD);
        addTest("add", rType(0, 2, 1, 0, 3), 8, 1'b1, 3, 3);
        addTest("sub", rType('h20, 2, 1, 0, 4), 12, 1'b1, 4, 9);
        addTest("and", rType(0, 2, 1, 7, 5), 16, 1'b1, 5, 4);
        addTest("or", rType(0, 2, 1, 6, 6), 20, 1'b1, 6, 32'hFFFFFFFF);
        addTest("xor", rType(0, 2, 1, 4, 7), 24, 1'b1, 7, 32'hFFFFFFFB);
        addTest("slt", rType(0, 1, 2, 2, 8), 28, 1'b1, 8, 1); // -3 < 6 signed
        addTest("sltu", rType(0, 1, 2, 3, 9), 32, 1'b1, 9, 0);
        addTest("sll", rType(0, 1, 1, 1, 10), 36, 1'b1, 10, 384);
        addTest("srl", rType(0, 1, 2, 5, 11), 40, 1'b1, 11, 32'h03FFFFFF);
        addTest("sra", rType('h20, 1, 2, 5, 12), 44, 1'b1, 12, 32'hFFFFFFFF);
        addTest("andi", iType('hF0, 2, 7, 13, opI), 48, 1'b1, 13, 32'hF0);
        addTest("ori", iType('h700, 1, 6, 14, opI), 52, 1'b1, 14, 32'h706);
        addTest("xori", iType(-1, 2, 4, 15, opI), 56, 1'b1, 15, 2);
        addTest("slti", iType(-2, 2, 2, 16, opI), 60, 1'b1, 16, 1);
        addTest("sltiu", iType(-1, 1, 3, 17, opI), 64, 1'b1, 17, 1);
        addTest("slli", iType(4, 1, 1, 18, opI), 68, 1'b1, 18, 32'h60);
        addTest("srli", iType(28, 2, 5, 19, opI), 72, 1'b1, 19, 32'hF);
        addTest("srai", iType('h401, 2, 5, 20, opI), 76, 1'b1, 20, 32'hFFFFFFFE);
        addTest("addi x0", iType(7, 1, 0, 0, opI), 80, 1'b0, 0, 0);
        addTest("read x0", rType(0, 1, 0, 0, 21), 84, 1'b1, 21, 6);
        addTest("sw", sType(10, 2, 1), 88, 1'b0, 0, 0); // Address 16
        addTest("lw", iType(16, 0, 2, 22, opL), 92, 1'b1, 22, 32'hFFFFFFFD);
        addTest("lw alias", iType(272, 0, 2, 23, opL), 96, 1'b1, 23, 32'hFFFFFFFD);
        addTest("beq taken", bType(16, 1, 1, 0), 100, 1'b0, 0, 0);
        addTest("beq not taken", bType(8, 2, 1, 0), 116, 1'b0, 0, 0);
        addTest("bne taken", bType(12, 2, 1, 1), 120, 1'b0, 0, 0);
        addTest("bne not taken", bType(8, 1, 1, 1), 132, 1'b0, 0, 0);
        addTest("blt taken", bType(8, 1, 2, 4), 136, 1'b0, 0, 0);
        addTest("blt not taken", bType(8, 2, 1, 4), 144, 1'b0, 0, 0);
        addTest("bge taken", bType(8, 2, 1, 5), 148, 1'b0, 0, 0);
        addTest("bge not taken", bType(8, 1, 2, 5), 156, 1'b0, 0, 0);
        addTest("bltu taken", bType(8, 2, 1, 6), 160, 1'b0, 0, 0);
        addTest("bltu not taken", bType(8, 1, 2, 6), 168, 1'b0, 0, 0);
        addTest("bgeu taken", bType(8, 1, 2, 7), 172, 1'b0, 0, 0);
        addTest("bgeu not taken", bType(8, 2, 1, 7), 180, 1'b0, 0, 0);
        addTest("beq backward", bType(-8, 0, 0, 0), 184, 1'b0, 0, 0);
        addTest("jal", jType(24, 25), 176, 1'b1, 25, 180);
        addTest("addi x26", iType(301, 0, 0, 26, opI), 200, 1'b1, 26, 301);
        addTest("jalr", iType(8, 26, 0, 27, opJr), 204, 1'b1, 27, 208); // Target 308
        addTest("unsupported", 32'hFFFFFFFF, 308, 1'b0, 0, 0);
        addTest("jal x0 back", jType(-12, 0), 312, 1'b0, 0, 0);
        addTest("add links", rType(0, 27, 25, 0, 28), 300, 1'b1, 28, 388);
        addTest("lui ignored", 32'h000012B7, 304, 1'b0, 0, 0);
        addTest("copy load", iType(0, 22, 0, 29, opI), 308, 1'b1, 29, 32'hFFFFFFFD);
    endtask

    initial begin
        rstn = 1'b0;
        forever #2 rstn = ~rstn;
    end

    initial begin
        cycles = 0;
        do begin
            @(posedge rstn);
            cycles++;
        end while (cycles < cycleLimit);
        $display("Timeout after %0d cycles before the program finished", cycles);
        $display("Test failures found");
        $finish;
    end

    initial begin
        rstN = 1'b0;
        instr = '0;
        errors = 0;
        checks = 0;
        buildProgram();
        cycleLimit = names.size() + 13;
        repeat (3) @(posedge rstn);
        rstN <= 1'b1; // Released on the third edge
        for (row = 0; row < names.size(); row++) begin
            instr <= instrs[row];
            @(negedge rstn);
            checks += 2;
            if (pc !== expPc[row]) begin
                $display("mismatch %s pc expected %h actual %h", names[row], expPc[row], pc);
                errors++;
            end
            if (wbEn !== expEn[row]) begin
                $display("mismatch %s wbEn expected %b actual %b", names[row], expEn[row],
                         wbEn);
                errors++;
            end
            if (expEn[row]) begin
                checks += 2;
                if (wbReg !== expReg[row]) begin
                    $display("mismatch %s wbReg expected %0d actual %0d", names[row],
                             expReg[row], wbReg);
                    errors++;
                end
                if (wbData !== expData[row]) begin
                    $display("mismatch %s wbData expected %h actual %h", names[row],
                             expData[row], wbData);
                    errors++;
                end
            end
            @(posedge rstn);
        end
        $display("Ran %0d rows, %0d checks, %0d errors", names.size(), checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== logic/rvCore.sv ====
`timescale 1ns/1ps

module rvCore import rvPkg::*; (
    input  logic  rstn,
    input  logic  rstN,
    input  word   instr,
    output word   pc,
    output logic  wbEn,
    output regIdx wbReg,
    output word   wbData
);

    regIdx rs1;
    regIdx rs2;
    word   rd1;
    word   rd2;
    word   nextPc;
    word   aluResult;
    word   storeData;
    word   linkAddr;
    logic  memWrite;
    logic  regWrite;
    wbSel  sel;
    regIdx rd;
    logic  we;
    regIdx wa;
    word   wd;

    ctrlIf ctrlBus ();

    always_ff @(posedge rstn or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

    instrDecode decodeStage (.instr(instr), .ctrl(ctrlBus.decode), .rs1(rs1), .rs2(rs2));

    regFile regs (
        .rstn(rstn), .rstN(rstN), .rs1(rs1), .rs2(rs2), .rd1(rd1), .rd2(rd2),
        .we(we), .wa(wa), .wd(wd)
    );

    aluExecute execStage (
        .ctrl(ctrlBus.execute), .pc(pc), .rd1(rd1), .rd2(rd2), .nextPc(nextPc),
        .aluResult(aluResult), .storeData(storeData), .linkAddr(linkAddr),
        .memWrite(memWrite), .regWrite(regWrite), .sel(sel), .rd(rd)
    );

    resultSelect resultStage (
        .rstn(rstn), .rstN(rstN), .aluResult(aluResult), .storeData(storeData),
        .linkAddr(linkAddr), .memWrite(memWrite), .regWrite(regWrite), .sel(sel),
        .rd(rd), .we(we), .wa(wa), .wd(wd)
    );

    assign wbEn   = we; // Retirement trace of the register write
    assign wbReg  = wa;
    assign wbData = wd;

endmodule

// ==== logic/resultSelect.sv ====
`timescale 1ns/1ps

module resultSelect import rvPkg::*; (
    input  logic  rstn,
    input  logic  rstN,
    input  word   aluResult,
    input  word   storeData,
    input  word   linkAddr,
    input  logic  memWrite,
    input  logic  regWrite,
    input  wbSel  sel,
    input  regIdx rd,
    output logic  we,
    output regIdx wa,
    output word   wd
);

    word                          mem [memWords];
    logic [$clog2(memWords)-1:0] memIdx;

    assign memIdx = aluResult[7:2]; // Word address, upper bits ignored

    always_ff @(posedge rstn or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < memWords; i++) begin
                mem[i] <= '0;
            end
        end else if (memWrite) begin
            mem[memIdx] <= storeData;
        end
    end

    always_comb begin
        case (sel)
            fromMem:  wd = mem[memIdx];
            fromLink: wd = linkAddr;
            default:  wd = aluResult;
        endcase
    end

    assign we = regWrite && (rd != 5'd0);
    assign wa = rd;

    // Decode never marks a store as a register write
    assert property (@(posedge rstn) disable iff (!rstN) !(memWrite && regWrite));

endmodule

// ==== logic/aluExecute.sv ====
`timescale 1ns/1ps

module aluExecute import rvPkg::*; (
    ctrlIf.execute ctrl,
    input  word    pc,
    input  word    rd1,
    input  word    rd2,
    output word    nextPc,
    output word    aluResult,
    output word    storeData,
    output word    linkAddr,
    output logic   memWrite,
    output logic   regWrite,
    output wbSel   sel,
    output regIdx  rd
);

    word        opB;
    logic [4:0] shamt;
    logic       isEq;
    logic       isLt;
    logic       isLtu;
    logic       taken;

    assign opB   = ctrl.useImm ? ctrl.imm : rd2;
    assign shamt = opB[4:0];

    always_comb begin
        case (ctrl.op)
            addOp:   aluResult = rd1 + opB;
            subOp:   aluResult = rd1 - opB;
            andOp:   aluResult = rd1 & opB;
            orOp:    aluResult = rd1 | opB;
            xorOp:   aluResult = rd1 ^ opB;
            sltOp:   aluResult = {31'd0, $signed(rd1) < $signed(opB)};
            sltuOp:  aluResult = {31'd0, rd1 < opB};
            sllOp:   aluResult = rd1 << shamt;
            srlOp:   aluResult = rd1 >> shamt;
            sraOp:   aluResult = word'($signed(rd1) >>> shamt);
            default: aluResult = rd1 + opB;
        endcase
    end

    // Branches always compare the two registers
    assign isEq  = (rd1 == rd2);
    assign isLt  = ($signed(rd1) < $signed(rd2));
    assign isLtu = (rd1 < rd2);

    always_comb begin
        case (ctrl.cond)
            beqC:    taken = isEq;
            bneC:    taken = !isEq;
            bltC:    taken = isLt;
            bgeC:    taken = !isLt;
            bltuC:   taken = isLtu;
            bgeuC:   taken = !isLtu;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        if (ctrl.isJalr) begin
            nextPc = (rd1 + ctrl.imm) & ~word'(1);
        end else if (ctrl.isJal || (ctrl.isBranch && taken)) begin
            nextPc = pc + ctrl.imm;
        end else begin
            nextPc = pc + 32'd4;
        end
    end

    assign linkAddr  = pc + 32'd4;
    assign storeData = rd2;
    assign memWrite  = ctrl.memWrite;
    assign regWrite  = ctrl.regWrite;
    assign sel       = ctrl.sel;
    assign rd        = ctrl.rd;

    // Next-pc mux relies on a single redirect kind
    always_comb begin
        assert ($onehot0({ctrl.isBranch, ctrl.isJal, ctrl.isJalr}));
    end

endmodule

// ==== logic/regFile.sv ====
`timescale 1ns/1ps

module regFile import rvPkg::*; (
    input  logic  rstn,
    input  logic  rstN,
    input  regIdx rs1,
    input  regIdx rs2,
    output word   rd1,
    output word   rd2,
    input  logic  we,
    input  regIdx wa,
    input  word   wd
);

    word regs [32];

    always_ff @(posedge rstn or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wa] <= wd;
        end
    end

    assign rd1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == 5'd0) ? '0 : regs[rs2];

    // x0 storage must stay zero across every write
    assert property (@(posedge rstn) disable iff (!rstN) regs[0] == '0);

endmodule

// ==== logic/instrDecode.sv ====
`timescale 1ns/1ps

module instrDecode import rvPkg::*; (
    input  word          instr,
    ctrlIf.decode        ctrl,
    output regIdx        rs1,
    output regIdx        rs2
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word        immI;
    word        immS;
    word        immB;
    word        immJ;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        ctrl.op       = addOp; // Unsupported encodings fall out as a no-op
        ctrl.useImm   = 1'b0;
        ctrl.imm      = immI;
        ctrl.isBranch = 1'b0;
        ctrl.cond     = beqC;
        ctrl.isJal    = 1'b0;
        ctrl.isJalr   = 1'b0;
        ctrl.regWrite = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.sel      = fromAlu;
        ctrl.rd       = instr[11:7];
        case (opcode)
            opReg: begin
                ctrl.regWrite = 1'b1;
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000:  ctrl.op = addOp;
                        3'b001:  ctrl.op = sllOp;
                        3'b010:  ctrl.op = sltOp;
                        3'b011:  ctrl.op = sltuOp;
                        3'b100:  ctrl.op = xorOp;
                        3'b101:  ctrl.op = srlOp;
                        3'b110:  ctrl.op = orOp;
                        default: ctrl.op = andOp;
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    ctrl.op = subOp;
                end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
                    ctrl.op = sraOp;
                end else begin
                    ctrl.regWrite = 1'b0;
                end
            end
            opImm: begin
                ctrl.useImm   = 1'b1;
                ctrl.regWrite = 1'b1;
                case (funct3)
                    3'b000: ctrl.op = addOp;
                    3'b010: ctrl.op = sltOp;
                    3'b011: ctrl.op = sltuOp;
                    3'b100: ctrl.op = xorOp;
                    3'b110: ctrl.op = orOp;
                    3'b111: ctrl.op = andOp;
                    3'b001: begin
                        ctrl.op       = sllOp;
                        ctrl.regWrite = (funct7 == 7'b0000000);
                    end
                    default: begin // SRLI or SRAI
                        ctrl.op       = instr[30] ? sraOp : srlOp;
                        ctrl.regWrite = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                    end
                endcase
            end
            opLoad: begin
                if (funct3 == 3'b010) begin
                    ctrl.useImm   = 1'b1;
                    ctrl.regWrite = 1'b1;
                    ctrl.sel      = fromMem;
                end
            end
            opStore: begin
                if (funct3 == 3'b010) begin
                    ctrl.useImm   = 1'b1;
                    ctrl.imm      = immS;
                    ctrl.memWrite = 1'b1;
                end
            end
            opJal: begin
                ctrl.imm      = immJ;
                ctrl.isJal    = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.sel      = fromLink;
            end
            opJalr: begin
                if (funct3 == 3'b000) begin
                    ctrl.useImm   = 1'b1;
                    ctrl.isJalr   = 1'b1;
                    ctrl.regWrite = 1'b1;
                    ctrl.sel      = fromLink;
                end
            end
            opBranch: begin
                ctrl.imm = immB;
                if (funct3 != 3'b010 && funct3 != 3'b011) begin
                    ctrl.isBranch = 1'b1;
                    ctrl.cond     = brCond'(funct3);
                end
            end
            default: ;
        endcase
    end

endmodule

// ==== logic/ctrlIf.sv ====
`timescale 1ns/1ps

interface ctrlIf import rvPkg::*; ();

    aluOp  op;
    logic  useImm;
    word   imm;
    logic  isBranch;
    brCond cond;
    logic  isJal;
    logic  isJalr;
    logic  regWrite;
    logic  memWrite;
    wbSel  sel;
    regIdx rd;

    modport decode (
        output op, useImm, imm, isBranch, cond, isJal, isJalr,
        output regWrite, memWrite, sel, rd
    );

    modport execute (
        input op, useImm, imm, isBranch, cond, isJal, isJalr,
        input regWrite, memWrite, sel, rd
    );

endinterface

// ==== logic/rvPkg.sv ====
package rvPkg;

    typedef logic [31:0] word;
    typedef logic [4:0] regIdx;

    typedef enum logic [3:0] {
        addOp,
        subOp,
        andOp,
        orOp,
        xorOp,
        sltOp,
        sltuOp,
        sllOp,
        srlOp,
        sraOp
    } aluOp;

    // Values follow the branch funct3 field
    typedef enum logic [2:0] {
        beqC  = 3'b000,
        bneC  = 3'b001,
        bltC  = 3'b100,
        bgeC  = 3'b101,
        bltuC = 3'b110,
        bgeuC = 3'b111
    } brCond;

    typedef enum logic [1:0] {
        fromAlu,
        fromMem,
        fromLink
    } wbSel;

    localparam logic [6:0] opReg    = 7'b0110011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;

    localparam int memWords = 64; // Data memory depth

endpackage
